//--- design/gba_io_consts.svh
`ifndef GBA_IO_CONSTS_SVH
`define GBA_IO_CONSTS_SVH

// Address map
`define IO_BASE         32'h0400_0000
`define WRAM_BASE       32'h0300_0000

// I/O register indices, register i sits at IO_BASE + 4*i
`define NUM_IO_REGS     5
`define LED_REG0_IDX    0
`define LED_REG1_IDX    1
`define LED_REG2_IDX    2
`define LED_REG3_IDX    3
`define KEYINPUT_IDX    4

// Work RAM depth in 32-bit words
`define WRAM_WORDS      256

// SNES pad scan timing, in system clocks
`define SNES_HALF_CLKS  4
`define SNES_GAP_CLKS   16

`endif

//--- design/gba_pkg.sv
`default_nettype none

package gba_pkg;

    // Access size as driven by the CPU, 2'b11 is unused
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } bus_size_t;

    // Bit k enables byte k of the word
    typedef logic [3:0] lane_mask_t;

    function automatic lane_mask_t lane_mask(input bus_size_t size, input logic [1:0] addr_lo);
        lane_mask_t mask;
        case (size)
            size_byte: mask = lane_mask_t'(4'b0001 << addr_lo);
            size_half: mask = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:   mask = 4'b1111;
        endcase
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- design/mem_bus_if.sv
`default_nettype none

// One target's view of a CPU access
interface mem_bus_if;
    logic                sel;
    logic                write;
    gba_pkg::lane_mask_t lane;
    logic [15:0]         index;
    logic [31:0]         wdata;
    logic [31:0]         rdata;

    modport host   (output sel, write, lane, index, wdata, input rdata);
    modport target (input sel, write, lane, index, wdata, output rdata);
endinterface

// LED debug registers, io_regs to led_controller
interface led_regs_if;
    logic [31:0] reg0, reg1, reg2, reg3;

    modport source (output reg0, reg1, reg2, reg3);
    modport sink   (input reg0, reg1, reg2, reg3);
endinterface

`default_nettype wire

//--- design/work_ram.sv
`default_nettype none

`include "gba_io_consts.svh"

module work_ram #(
    parameter int DEPTH = `WRAM_WORDS
) (
    input logic       clock,
    mem_bus_if.target bus
);

    // DEPTH is a power of two, so dropping upper index bits wraps it
    localparam int AW = $clog2(DEPTH);

    logic [31:0]   mem [DEPTH];
    logic [31:0]   rdata_q;
    logic [AW-1:0] addr;

    assign addr = bus.index[AW-1:0];

    always_ff @(posedge clock) begin
        if (bus.sel && bus.write) begin
            for (int k = 0; k < 4; k++) begin
                if (bus.lane[k]) begin
                    mem[addr][8*k +: 8] <= bus.wdata[8*k +: 8];
                end
            end
        end
    end

    // Read data is ready the cycle after select
    always_ff @(posedge clock) begin
        if (bus.sel && !bus.write) begin
            rdata_q <= mem[addr];
        end
    end

    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/io_regs.sv
`default_nettype none

`include "gba_io_consts.svh"

module io_regs (
    input  logic        clock,
    input  logic        rst,
    input  logic [15:0] buttons,
    mem_bus_if.target   bus,
    led_regs_if.source  leds
);

    logic [31:0] led_reg [4];
    logic        wr_en;

    // KEYINPUT is read only, and nothing exists past it
    assign wr_en = bus.sel && bus.write &&
                   (bus.index < `NUM_IO_REGS) && (bus.index != `KEYINPUT_IDX);

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                led_reg[i] <= '0;
            end
        end else if (wr_en) begin
            for (int k = 0; k < 4; k++) begin
                if (bus.lane[k]) begin
                    led_reg[bus.index[1:0]][8*k +: 8] <= bus.wdata[8*k +: 8];
                end
            end
        end
    end

    always_comb begin
        if (bus.index >= `NUM_IO_REGS) begin
            bus.rdata = '0;
        end else if (bus.index == `KEYINPUT_IDX) begin
            bus.rdata = {16'h0000, buttons};
        end else begin
            bus.rdata = led_reg[bus.index[1:0]];
        end
    end

    assign leds.reg0 = led_reg[`LED_REG0_IDX];
    assign leds.reg1 = led_reg[`LED_REG1_IDX];
    assign leds.reg2 = led_reg[`LED_REG2_IDX];
    assign leds.reg3 = led_reg[`LED_REG3_IDX];

    // Decoder in mem_top limits the I/O window to 256 words
    assert property (@(posedge clock) disable iff (rst)
        bus.sel |-> bus.index <= 16'd255);

endmodule

`default_nettype wire

//--- design/mem_top.sv
`default_nettype none

`include "gba_io_consts.svh"

module mem_top (
    input  logic               clock,
    input  logic               rst,
    input  logic [31:0]        bus_addr,
    input  logic [31:0]        bus_wdata,
    input  gba_pkg::bus_size_t bus_size,
    input  logic               bus_write,
    input  logic               bus_req,
    input  logic [15:0]        buttons,
    output logic [31:0]        bus_rdata,
    output logic               bus_pause,
    led_regs_if.source         leds
);

    localparam logic [31:0] IO_BASE_ADDR   = `IO_BASE;
    localparam logic [31:0] WRAM_BASE_ADDR = `WRAM_BASE;

    mem_bus_if wram_bus ();
    mem_bus_if io_bus ();

    logic                wram_hit;
    logic                io_hit;
    logic                rd_pending;
    gba_pkg::lane_mask_t lane;

    // Work RAM owns a 16MB region, I/O decodes only its first 256 words
    assign wram_hit = bus_req && (bus_addr[31:24] == WRAM_BASE_ADDR[31:24]);
    assign io_hit   = bus_req && (bus_addr[31:10] == IO_BASE_ADDR[31:10]);

    assign lane = gba_pkg::lane_mask(bus_size, bus_addr[1:0]);

    assign wram_bus.sel   = wram_hit;
    assign wram_bus.write = bus_write;
    assign wram_bus.lane  = lane;
    assign wram_bus.index = bus_addr[17:2];
    assign wram_bus.wdata = bus_wdata;

    assign io_bus.sel   = io_hit;
    assign io_bus.write = bus_write;
    assign io_bus.lane  = lane;
    assign io_bus.index = bus_addr[17:2];
    assign io_bus.wdata = bus_wdata;

    // RAM read data arrives one clock late, so hold off the CPU once
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= wram_hit && !bus_write && !rd_pending;
        end
    end

    assign bus_pause = wram_hit && !bus_write && !rd_pending;

    always_comb begin
        if (wram_hit) begin
            bus_rdata = wram_bus.rdata;
        end else if (io_hit) begin
            bus_rdata = io_bus.rdata;
        end else begin
            bus_rdata = '0;
        end
    end

    work_ram wram (.clock, .bus(wram_bus));

    io_regs io (.clock, .rst, .buttons, .bus(io_bus), .leds);

    assert property (@(posedge clock) disable iff (rst)
        bus_req |-> bus_size inside {gba_pkg::size_byte, gba_pkg::size_half,
                                     gba_pkg::size_word});

    // The CPU must keep the same RAM read up through the pause
    assert property (@(posedge clock) disable iff (rst)
        rd_pending |-> wram_hit && !bus_write && $stable(bus_addr));

endmodule

`default_nettype wire

//--- design/controller.sv
`default_nettype none

`include "gba_io_consts.svh"

module controller (
    input  logic        clock,
    input  logic        rst,
    input  logic        serial_data,
    output logic        data_latch,
    output logic        data_clock,
    output logic [15:0] buttons
);

    localparam int HALF_CLKS  = `SNES_HALF_CLKS;
    localparam int LATCH_CLKS = 2 * `SNES_HALF_CLKS;
    localparam int GAP_CLKS   = `SNES_GAP_CLKS;

    typedef enum logic [1:0] {S_GAP, S_LATCH, S_CLK_HI, S_CLK_LO} state_t;

    state_t      state;
    logic [7:0]  tick;
    logic [3:0]  pulse;
    logic [15:0] shift;

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= S_GAP;
            tick    <= '0;
            pulse   <= '0;
            buttons <= '0;
        end else begin
            tick <= tick + 8'd1;
            case (state)
                S_GAP: if (tick == GAP_CLKS - 1) begin
                    state <= S_LATCH;
                    tick  <= '0;
                end
                S_LATCH: if (tick == LATCH_CLKS - 1) begin
                    state <= S_CLK_HI;
                    tick  <= '0;
                    pulse <= '0;
                end
                S_CLK_HI: if (tick == HALF_CLKS - 1) begin
                    state <= S_CLK_LO;
                    tick  <= '0;
                end
                S_CLK_LO: if (tick == HALF_CLKS - 1) begin
                    tick <= '0;
                    if (pulse == 4'd15) begin
                        // Pad reports pressed as 0
                        state   <= S_GAP;
                        buttons <= ~shift;
                    end else begin
                        state <= S_CLK_HI;
                        pulse <= pulse + 4'd1;
                    end
                end
                default: state <= S_GAP;
            endcase
        end
    end

    // Bit 0 at end of latch, bits 1..15 at the end of pulses 1..15
    always_ff @(posedge clock) begin
        if ((state == S_LATCH && tick == LATCH_CLKS - 1) ||
            (state == S_CLK_HI && tick == HALF_CLKS - 1 && pulse != 4'd15)) begin
            shift <= {serial_data, shift[15:1]};
        end
    end

    assign data_latch = (state == S_LATCH);
    assign data_clock = (state == S_CLK_HI);

    assert property (@(posedge clock) disable iff (rst) !(data_latch && data_clock));

endmodule

`default_nettype wire

//--- design/led_controller.sv
`default_nettype none

module led_controller (
    input  logic [7:0]  sw,
    input  logic [15:0] buttons,
    led_regs_if.sink    leds,
    output logic [7:0]  ld
);

    logic [31:0] word;

    always_comb begin
        case (sw[3:2])
            2'd0:    word = leds.reg0;
            2'd1:    word = leds.reg1;
            2'd2:    word = leds.reg2;
            default: word = leds.reg3;
        endcase
    end

    // Switches 0..15 pick a register byte, anything else shows the pad
    always_comb begin
        if (sw[7:4] == 4'h0) begin
            ld = word[8*sw[1:0] +: 8];
        end else begin
            ld = sw[7] ? buttons[15:8] : buttons[7:0];
        end
    end

endmodule

`default_nettype wire

//--- design/gba_io_top.sv
`default_nettype none

module gba_io_top (
    input  logic               clock,
    input  logic               rst,
    input  logic [31:0]        bus_addr,
    input  logic [31:0]        bus_wdata,
    input  gba_pkg::bus_size_t bus_size,
    input  logic               bus_write,
    input  logic               bus_req,
    input  logic [7:0]         sw,
    input  logic               serial_data,
    output logic [31:0]        bus_rdata,
    output logic               bus_pause,
    output logic [7:0]         ld,
    output logic               data_latch,
    output logic               data_clock
);

    logic [15:0] buttons;

    led_regs_if led_regs ();

    // CPU side memory map
    mem_top mem (
        .clock, .rst, .bus_addr, .bus_wdata, .bus_size, .bus_write, .bus_req,
        .buttons, .bus_rdata, .bus_pause, .leds(led_regs)
    );

    // SNES gamepad scanner
    controller cont (
        .clock, .rst, .serial_data, .data_latch, .data_clock, .buttons
    );

    // Debug view on the board LEDs
    led_controller leds (
        .sw, .buttons, .leds(led_regs), .ld
    );

endmodule

`default_nettype wire

//--- tb/snes_pad_model.sv
`default_nettype none

// SNES gamepad shift register, pressed buttons read as 0 on the wire
module snes_pad_model (
    input  logic        data_latch,
    input  logic        data_clock,
    input  logic [15:0] pattern,
    output logic        serial_data
);

    logic [15:0] sr;

    initial sr = 16'hffff;

    // Latch rise loads the pattern, each clock rise moves to the next bit
    always @(posedge data_latch or posedge data_clock) begin
        if (data_latch) begin
            sr <= pattern;
        end else begin
            sr <= {1'b1, sr[15:1]};
        end
    end

    assign serial_data = sr[0];

endmodule

`default_nettype wire

//--- tb/tb_gba_io.sv
`default_nettype none

`include "gba_io_consts.svh"

module tb_gba_io;
    localparam int OP_WR = 0, OP_RD = 1, OP_SW = 2, OP_SCAN = 3;
    localparam logic [31:0] IO = `IO_BASE;
    localparam logic [31:0] WRAM = `WRAM_BASE;

    logic clock = 1'b0;
    logic rst, bus_write, bus_req, serial_data, bus_pause, data_latch, data_clock;
    logic [31:0] bus_addr, bus_wdata, bus_rdata;
    logic [7:0] sw, ld;
    logic [15:0] pad_pattern;
    gba_pkg::bus_size_t bus_size;

    // Stimulus table, one entry per row
    int row_test[80], row_op[80];
    logic [31:0] row_addr[80], row_data[80], row_exp[80];
    gba_pkg::bus_size_t row_size[80];
    int n_rows = 0, checks = 0, errors = 0;
    int test_errs[6] = '{0, 0, 0, 0, 0, 0};
    string test_name[6] = '{"", "reset state", "work RAM", "LED registers", "controller",
                            "ignored accesses"};
    bit timed_out = 1'b0;

    // Reference model of what the bus should return
    logic [31:0] ram_m[256];
    logic [31:0] led_m[4] = '{0, 0, 0, 0};
    logic [31:0] key_m = 32'h0;
    logic [31:0] lfsr = 32'habc530fe;

    always #50 clock = ~clock;

    gba_io_top dut (.*);

    snes_pad_model pad (.data_latch, .data_clock, .pattern(pad_pattern), .serial_data);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [3:0] lane_enables(input gba_pkg::bus_size_t s, input logic [1:0] lo);
        if (s == gba_pkg::size_byte) return 4'b0001 << lo;
        if (s == gba_pkg::size_half) return lo[1] ? 4'b1100 : 4'b0011;
        return 4'b1111;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, wd, input logic [3:0] en);
        logic [31:0] w;
        w = old;
        for (int k = 0; k < 4; k++) begin
            if (en[k]) w[8*k +: 8] = wd[8*k +: 8];
        end
        return w;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] a);
        if (a[31:24] == WRAM[31:24]) return ram_m[a[9:2]];
        if (a[31:10] == IO[31:10] && a[17:2] < 4) return led_m[a[3:2]];
        if (a[31:10] == IO[31:10] && a[17:2] == 4) return key_m;
        return 32'h0;
    endfunction

    task automatic add_row(input int t, o, input logic [31:0] a, input gba_pkg::bus_size_t s,
                           input logic [31:0] d, e);
        row_test[n_rows] = t;
        row_op[n_rows] = o;
        row_addr[n_rows] = a;
        row_size[n_rows] = s;
        row_data[n_rows] = d;
        row_exp[n_rows] = e;
        n_rows++;
    endtask

    task automatic write_row(input int t, input logic [31:0] a, input gba_pkg::bus_size_t s,
                             input logic [31:0] d);
        add_row(t, OP_WR, a, s, d, 32'h0);
        if (a[31:24] == WRAM[31:24]) begin
            ram_m[a[9:2]] = merge_lanes(ram_m[a[9:2]], d, lane_enables(s, a[1:0]));
        end else if (a[31:10] == IO[31:10] && a[17:2] < 4) begin
            led_m[a[3:2]] = merge_lanes(led_m[a[3:2]], d, lane_enables(s, a[1:0]));
        end
    endtask

    task automatic read_row(input int t, input logic [31:0] a);
        add_row(t, OP_RD, a, gba_pkg::size_word, 32'h0, expected_read(a));
    endtask

    task automatic check_value(input int t, input string name, input logic [31:0] actual, exp);
        checks++;
        if (actual !== exp) begin
            errors++;
            test_errs[t]++;
            $display("FAIL %s: got %h, expected %h", name, actual, exp);
        end
    endtask

    task automatic report_test(input int t);
        $display("Test %0d %s: %s", t, test_name[t], (test_errs[t] == 0) ? "passed" : "failed");
    endtask

    // Holds the request until a cycle with bus_pause low
    task automatic bus_access(input logic wr, input logic [31:0] a, input gba_pkg::bus_size_t s,
                              input logic [31:0] d, output logic [31:0] rdata, output int pauses);
        int cycles;
        bit done;
        cycles = 0;
        done = 1'b0;
        pauses = 0;
        rdata = 32'h0;
        @(posedge clock);
        bus_req <= 1'b1;
        bus_write <= wr;
        bus_addr <= a;
        bus_size <= s;
        bus_wdata <= d;
        while (!done && cycles < 20) begin
            @(posedge clock);
            cycles++;
            if (bus_pause) begin
                pauses++;
            end else begin
                done = 1'b1;
                rdata = bus_rdata;
            end
        end
        bus_req <= 1'b0;
        bus_write <= 1'b0;
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: access to %h still paused after 20 cycles", a);
        end
    endtask

    task automatic wait_latch(input bit need_low);
        int cycles;
        bit seen_low;
        bit done;
        cycles = 0;
        seen_low = !need_low;
        done = 1'b0;
        while (!timed_out && !done && cycles < 400) begin
            @(posedge clock);
            cycles++;
            if (!data_latch) seen_low = 1'b1;
            else if (seen_low) done = 1'b1;
        end
        if (!timed_out && !done) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: no data_latch pulse seen within 400 cycles");
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic [15:0] pat;
        int pauses;
        int cur;
        rst = 1'b1;
        bus_addr = 32'h0;
        bus_wdata = 32'h0;
        bus_size = gba_pkg::size_word;
        bus_write = 1'b0;
        bus_req = 1'b0;
        sw = 8'h00;
        pad_pattern = 16'hffff;

        // Work RAM: full words, then byte and halfword lanes
        write_row(2, WRAM + 32'h010, gba_pkg::size_word, 32'h1234_5678);
        read_row(2, WRAM + 32'h010);
        write_row(2, WRAM + 32'h104, gba_pkg::size_word, 32'hcafe_f00d);
        write_row(2, WRAM + 32'h106, gba_pkg::size_byte, 32'h00a5_0000);
        write_row(2, WRAM + 32'h104, gba_pkg::size_half, 32'h0000_beef);
        read_row(2, WRAM + 32'h104);
        write_row(2, WRAM + 32'h3fc, gba_pkg::size_word, 32'hffff_ffff);
        write_row(2, WRAM + 32'h3fe, gba_pkg::size_half, 32'h55aa_0000);
        write_row(2, WRAM + 32'h3fd, gba_pkg::size_byte, 32'h0000_7700);
        read_row(2, WRAM + 32'h3fc);
        read_row(2, WRAM + 32'h010);

        for (int r = 0; r < 4; r++) begin
            write_row(3, IO + 4 * r, gba_pkg::size_word, 32'h1032_5476 + r * 32'h2121_2121);
        end
        write_row(3, IO + 11, gba_pkg::size_byte, 32'h5a00_0000);
        write_row(3, IO + 12, gba_pkg::size_half, 32'h0000_c3d2);
        write_row(3, IO + 2, gba_pkg::size_half, 32'h9e1f_0000);
        for (int r = 0; r < 4; r++) read_row(3, IO + 4 * r);
        for (int s = 0; s < 16; s++) begin
            add_row(3, OP_SW, 32'h0, gba_pkg::size_word, s, led_m[s / 4][8 * (s % 4) +: 8]);
        end

        // Pad pattern, one LFSR step per bit
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_next(lfsr);
            pat[b] = lfsr[0];
        end
        add_row(4, OP_SCAN, 32'h0, gba_pkg::size_word, {16'h0, pat}, 32'h0);
        key_m = {16'h0, ~pat};
        read_row(4, IO + 16);
        add_row(4, OP_SW, 32'h0, gba_pkg::size_word, 32'h80, key_m[15:8]);
        add_row(4, OP_SW, 32'h0, gba_pkg::size_word, 32'h10, key_m[7:0]);

        // KEYINPUT and index 7 share low index bits with LED registers 0 and 3
        write_row(5, IO + 16, gba_pkg::size_word, 32'hffff_ffff);
        read_row(5, IO + 16);
        write_row(5, IO + 28, gba_pkg::size_word, 32'h0bad_0bad);
        read_row(5, IO + 0);
        read_row(5, IO + 12);
        write_row(5, 32'h0600_0000, gba_pkg::size_word, 32'hdead_beef);
        read_row(5, 32'h0600_0000);
        read_row(5, IO + 20);
        read_row(5, IO + 28);
        read_row(5, IO + 32'h100);

        repeat (10) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        check_value(1, "data_latch", data_latch, 32'h0);
        check_value(1, "data_clock", data_clock, 32'h0);
        check_value(1, "bus_pause", bus_pause, 32'h0);
        check_value(1, "ld", ld, 32'h0);
        report_test(1);

        cur = 2;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            if (row_test[i] != cur) begin
                report_test(cur);
                cur = row_test[i];
            end
            case (row_op[i])
                OP_WR, OP_RD: begin
                    bus_access(row_op[i] == OP_WR, row_addr[i], row_size[i], row_data[i],
                               rdata, pauses);
                    if (!timed_out && row_op[i] == OP_RD) begin
                        check_value(cur, "bus_rdata", rdata, row_exp[i]);
                    end
                    // Only work RAM reads stall, for exactly one cycle
                    if (!timed_out) begin
                        check_value(cur, "bus_pause cycles", pauses,
                            (row_op[i] == OP_RD && row_addr[i][31:24] == WRAM[31:24]) ? 1 : 0);
                    end
                end
                OP_SW: begin
                    @(posedge clock);
                    sw <= row_data[i][7:0];
                    @(posedge clock);
                    check_value(cur, "ld", ld, row_exp[i]);
                end
                default: begin
                    // Change the pattern mid latch so the next full scan sees it
                    wait_latch(1'b0);
                    pad_pattern <= row_data[i][15:0];
                    wait_latch(1'b1);
                    wait_latch(1'b1);
                end
            endcase
        end
        if (timed_out) begin
            test_errs[cur]++;
        end
        report_test(cur);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/gba_pkg.sv
design/mem_bus_if.sv
design/work_ram.sv
design/io_regs.sv
design/mem_top.sv
design/controller.sv
design/led_controller.sv
design/gba_io_top.sv
tb/snes_pad_model.sv
tb/tb_gba_io.sv
